//--- logic/rv_alu.sv
// ----------------------------------------------------------
// Single-cycle integer ALU with operand selection. One
// 33-bit adder serves ADD, SUB, SLT and SLTU.
// ----------------------------------------------------------
module rv_alu import rv_exec_pkg::*; (
    input  alu_op_t alu_op_i,
    input  logic    a_sel_pc_i,
    input  logic    b_sel_imm_i,
    input  word_t   src1_i,
    input  word_t   src2_i,
    input  word_t   pc_i,
    input  word_t   imm_i,
    output word_t   rslt_o
);

    word_t       opa;
    word_t       opb;
    logic        is_signed;
    logic        is_neg;
    logic [32:0] sum;
    logic [4:0]  shamt;

    assign opa = a_sel_pc_i  ? pc_i  : src1_i;
    assign opb = b_sel_imm_i ? imm_i : src2_i;

    assign is_signed = (alu_op_i == ALU_SLT);
    assign is_neg    = (alu_op_i == ALU_SUB) || (alu_op_i == ALU_SLT)
                    || (alu_op_i == ALU_SLTU);

    // Extend by one bit so bit 32 is the borrow or the signed compare
    assign sum = {is_signed & opa[31], opa}
               + ({is_signed & opb[31], opb} ^ {33{is_neg}})
               + {32'b0, is_neg};

    assign shamt = opb[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD, ALU_SUB: rslt_o = sum[31:0];
            ALU_SLT, ALU_SLTU: rslt_o = {31'b0, sum[32]};
            ALU_SLL:    rslt_o = opa << shamt;
            ALU_SRL:    rslt_o = opa >> shamt;
            ALU_SRA:    rslt_o = $signed(opa) >>> shamt;
            ALU_XOR:    rslt_o = opa ^ opb;
            ALU_OR:     rslt_o = opa | opb;
            ALU_AND:    rslt_o = opa & opb;
            ALU_PASS_B: rslt_o = opb;           // LUI
            default:    rslt_o = '0;
        endcase
    end

endmodule

//--- logic/rv_decoder.sv
// ----------------------------------------------------------
// Combinational RV32IM decoder for OP, OP-IMM, LUI and AUIPC.
// Picks the unit and operation, the operand sources and the
// immediate. Anything else comes out as UNIT_NONE.
// ----------------------------------------------------------
`include "rv_exec_cfg.svh"

module rv_decoder import rv_exec_pkg::*; (
    input  word_t     instr_i,
    output unit_sel_t unit_sel_o,
    output alu_op_t   alu_op_o,
    output mul_op_t   mul_op_o,
    output div_op_t   div_op_o,
    output logic      a_sel_pc_o,
    output logic      b_sel_imm_o,
    output word_t     imm_o
);

    logic [4:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       is_u_type;

    assign op        = instr_i[6:2];
    assign f3        = instr_i[14:12];
    assign f7        = instr_i[31:25];
    assign is_u_type = (op == `RV_OP_LUI) || (op == `RV_OP_AUIPC);

    // U-type keeps the upper 20 bits, I-type sign-extends bit 31
    assign imm_o = is_u_type ? {instr_i[31:12], 12'b0}
                             : {{20{instr_i[31]}}, instr_i[31:20]};

    always_comb begin
        unit_sel_o  = UNIT_NONE;
        alu_op_o    = ALU_ADD;
        mul_op_o    = mul_op_t'(f3[1:0]);
        div_op_o    = div_op_t'(f3[1:0]);
        a_sel_pc_o  = 1'b0;
        b_sel_imm_o = 1'b0;

        if (instr_i[1:0] == 2'b11) begin  // 16-bit encodings are not supported
            case (op)
                `RV_OP_OPIMM: begin
                    unit_sel_o  = UNIT_ALU;
                    b_sel_imm_o = 1'b1;
                    case (f3)
                        3'd0: alu_op_o = ALU_ADD;
                        3'd2: alu_op_o = ALU_SLT;
                        3'd3: alu_op_o = ALU_SLTU;
                        3'd4: alu_op_o = ALU_XOR;
                        3'd6: alu_op_o = ALU_OR;
                        3'd7: alu_op_o = ALU_AND;
                        3'd1: if (f7 != 7'h00) unit_sel_o = UNIT_NONE;
                              else             alu_op_o   = ALU_SLL;
                        default: begin              // Right shifts
                            if (f7 == 7'h00)           alu_op_o   = ALU_SRL;
                            else if (f7 == `RV_F7_ALT) alu_op_o   = ALU_SRA;
                            else                       unit_sel_o = UNIT_NONE;
                        end
                    endcase
                end
                `RV_OP_OP: begin
                    if (f7 == `RV_F7_MULDIV) begin
                        unit_sel_o = f3[2] ? UNIT_DIV : UNIT_MUL;
                    end else if (f7 == 7'h00) begin
                        unit_sel_o = UNIT_ALU;
                        case (f3)
                            3'd0:    alu_op_o = ALU_ADD;
                            3'd1:    alu_op_o = ALU_SLL;
                            3'd2:    alu_op_o = ALU_SLT;
                            3'd3:    alu_op_o = ALU_SLTU;
                            3'd4:    alu_op_o = ALU_XOR;
                            3'd5:    alu_op_o = ALU_SRL;
                            3'd6:    alu_op_o = ALU_OR;
                            default: alu_op_o = ALU_AND;
                        endcase
                    end else if (f7 == `RV_F7_ALT && f3 == 3'd0) begin
                        unit_sel_o = UNIT_ALU;
                        alu_op_o   = ALU_SUB;
                    end else if (f7 == `RV_F7_ALT && f3 == 3'd5) begin
                        unit_sel_o = UNIT_ALU;
                        alu_op_o   = ALU_SRA;
                    end
                end
                `RV_OP_LUI: begin
                    unit_sel_o  = UNIT_ALU;
                    alu_op_o    = ALU_PASS_B;
                    b_sel_imm_o = 1'b1;
                end
                `RV_OP_AUIPC: begin
                    unit_sel_o  = UNIT_ALU;
                    a_sel_pc_o  = 1'b1;             // PC + upper immediate
                    b_sel_imm_o = 1'b1;
                end
                default: unit_sel_o = UNIT_NONE;
            endcase
        end
    end

endmodule

//--- logic/rv_divider.sv
// ----------------------------------------------------------
// Restoring radix-2 divider for DIV, DIVU, REM and REMU.
// Works on magnitudes and fixes the signs at the end. A zero
// divisor skips the iterations.
// ----------------------------------------------------------
`include "rv_exec_cfg.svh"

module rv_divider import rv_exec_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    start_i,
    input  div_op_t div_op_i,
    input  word_t   src1_i,
    input  word_t   src2_i,
    output logic    valid_o,
    output word_t   rslt_o
);

    localparam int unsigned CNT_W = $clog2(`RV_DIV_STEPS);

    div_state_t       state_q;
    logic [CNT_W-1:0] cnt_q;
    word_t            divisor_q;
    word_t            rem_q;       // Holds the dividend until CHECK
    word_t            quo_q;
    logic             is_rem_q;
    logic             dvd_neg_q;
    logic             dvs_neg_q;
    logic             quo_neg_q;
    logic             rem_neg_q;

    logic             is_signed;
    logic [32:0]      shifted;
    logic [33:0]      diff;
    logic             q_bit;

    assign is_signed = (div_op_i == OP_DIV) || (div_op_i == OP_REM);

    // One step: shift in the next dividend bit, try to subtract
    assign shifted = {rem_q, quo_q[31]};
    assign diff    = {1'b0, shifted} - {2'b0, divisor_q};
    assign q_bit   = ~diff[33];

    // ------------------------------------------------------
    // State machine
    // ------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= DIV_IDLE;
        end else begin
            case (state_q)
                DIV_IDLE:  if (start_i) state_q <= DIV_CHECK;
                DIV_CHECK: state_q <= (divisor_q == '0) ? DIV_RET : DIV_EXEC;
                DIV_EXEC:  if (cnt_q == '0) state_q <= DIV_RET;
                default:   state_q <= DIV_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------
    // Datapath
    // ------------------------------------------------------
    always_ff @(posedge clk_i) begin
        case (state_q)
            DIV_IDLE: if (start_i) begin
                is_rem_q  <= (div_op_i == OP_REM) || (div_op_i == OP_REMU);
                dvd_neg_q <= is_signed & src1_i[31];
                dvs_neg_q <= is_signed & src2_i[31];
                rem_q     <= src1_i;
                divisor_q <= src2_i;
            end
            DIV_CHECK: if (divisor_q == '0) begin
                quo_q     <= '1;                 // Remainder keeps the dividend
                quo_neg_q <= 1'b0;
                rem_neg_q <= 1'b0;
            end else begin
                divisor_q <= dvs_neg_q ? -divisor_q : divisor_q;
                quo_q     <= dvd_neg_q ? -rem_q : rem_q;
                rem_q     <= '0;
                quo_neg_q <= dvd_neg_q ^ dvs_neg_q;
                rem_neg_q <= dvd_neg_q;          // Remainder takes the dividend sign
                cnt_q     <= CNT_W'(`RV_DIV_STEPS - 1);
            end
            DIV_EXEC: begin
                rem_q <= q_bit ? diff[31:0] : shifted[31:0];
                quo_q <= {quo_q[30:0], q_bit};
                cnt_q <= cnt_q - 1'b1;
            end
            default: ;
        endcase
    end

    assign valid_o = (state_q == DIV_RET);
    assign rslt_o  = is_rem_q ? (rem_neg_q ? -rem_q : rem_q)
                              : (quo_neg_q ? -quo_q : quo_q);

endmodule

//--- logic/rv_exec_cfg.svh
// ----------------------------------------------------------
// Fixed encodings and sizes for the RV32IM execute unit.
// Include wherever opcodes, funct7 values or the word width
// are needed.
// ----------------------------------------------------------
`ifndef RV_EXEC_CFG_SVH
`define RV_EXEC_CFG_SVH

`define RV_XLEN      32

// Major opcodes, instr[6:2]
`define RV_OP_OP     5'b01100
`define RV_OP_OPIMM  5'b00100
`define RV_OP_LUI    5'b01101
`define RV_OP_AUIPC  5'b00101

`define RV_F7_MULDIV 7'h01     // M-extension marker
`define RV_F7_ALT    7'h20     // SUB and SRA

`define RV_DIV_STEPS 32        // One quotient bit per step

`endif

//--- logic/rv_exec_ctrl.sv
// ----------------------------------------------------------
// Issue and completion control. Takes one instruction at a
// time, starts the multiplier or divider when needed and
// holds the result for the single-cycle done strobe.
// ----------------------------------------------------------
module rv_exec_ctrl import rv_exec_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      issue_i,
    input  unit_sel_t unit_sel_i,
    input  word_t     alu_rslt_i,
    input  logic      mul_valid_i,
    input  word_t     mul_rslt_i,
    input  logic      div_valid_i,
    input  word_t     div_rslt_i,
    output logic      mul_start_o,
    output logic      div_start_o,
    output logic      busy_o,
    output logic      done_o,
    output logic      illegal_o,
    output word_t     rslt_o
);

    ctrl_state_t state_q;
    logic        illegal_q;
    word_t       rslt_q;
    logic        accept;

    assign accept      = issue_i && (state_q == CTRL_IDLE);   // Ignored while busy
    assign mul_start_o = accept && (unit_sel_i == UNIT_MUL);
    assign div_start_o = accept && (unit_sel_i == UNIT_DIV);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= CTRL_IDLE;
            illegal_q <= 1'b0;
        end else begin
            case (state_q)
                CTRL_IDLE: if (accept) begin
                    illegal_q <= (unit_sel_i == UNIT_NONE);
                    if (unit_sel_i == UNIT_ALU || unit_sel_i == UNIT_NONE)
                        state_q <= CTRL_DONE;
                    else
                        state_q <= CTRL_WAIT_UNIT;
                end
                CTRL_WAIT_UNIT: if (mul_valid_i || div_valid_i) state_q <= CTRL_DONE;
                default: state_q <= CTRL_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------
    // Result register
    // ------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (accept && unit_sel_i == UNIT_ALU)       rslt_q <= alu_rslt_i;
        else if (accept && unit_sel_i == UNIT_NONE) rslt_q <= '0;
        else if (state_q == CTRL_WAIT_UNIT) begin
            if (mul_valid_i)      rslt_q <= mul_rslt_i;
            else if (div_valid_i) rslt_q <= div_rslt_i;
        end
    end

    assign busy_o    = (state_q != CTRL_IDLE);
    assign done_o    = (state_q == CTRL_DONE);
    assign illegal_o = done_o && illegal_q;
    assign rslt_o    = rslt_q;

endmodule

//--- logic/rv_exec_pkg.sv
// ----------------------------------------------------------
// Shared types of the execute unit: data words, register
// indices, operation codes and the FSM state encodings.
// ----------------------------------------------------------
`include "rv_exec_cfg.svh"

package rv_exec_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0]          reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_XOR, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_t;

    // Values follow funct3[1:0] of the M-extension encodings
    typedef enum logic [1:0] {
        OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU
    } mul_op_t;

    typedef enum logic [1:0] {
        OP_DIV, OP_DIVU, OP_REM, OP_REMU
    } div_op_t;

    typedef enum logic [1:0] {
        UNIT_ALU, UNIT_MUL, UNIT_DIV, UNIT_NONE
    } unit_sel_t;

    typedef enum logic [1:0] {
        CTRL_IDLE, CTRL_WAIT_UNIT, CTRL_DONE
    } ctrl_state_t;

    typedef enum logic [1:0] {
        DIV_IDLE, DIV_CHECK, DIV_EXEC, DIV_RET
    } div_state_t;

endpackage

//--- logic/rv_exec_unit.sv
// ----------------------------------------------------------
// Standalone RV32IM integer execute unit. Pulse issue_i with
// the instruction, PC and operands; wait for done_o.
// ----------------------------------------------------------
module rv_exec_unit import rv_exec_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  issue_i,
    input  word_t instr_i,
    input  word_t pc_i,
    input  word_t src1_i,
    input  word_t src2_i,
    output logic  busy_o,
    output logic  done_o,
    output logic  illegal_o,
    output word_t rslt_o
);

    unit_sel_t unit_sel;
    alu_op_t   alu_op;
    mul_op_t   mul_op;
    div_op_t   div_op;
    logic      a_sel_pc;
    logic      b_sel_imm;
    word_t     imm;
    word_t     alu_rslt;
    logic      mul_start;
    logic      mul_valid;
    word_t     mul_rslt;
    logic      div_start;
    logic      div_valid;
    word_t     div_rslt;

    rv_decoder decoder_inst (
        .instr_i     (instr_i),
        .unit_sel_o  (unit_sel),
        .alu_op_o    (alu_op),
        .mul_op_o    (mul_op),
        .div_op_o    (div_op),
        .a_sel_pc_o  (a_sel_pc),
        .b_sel_imm_o (b_sel_imm),
        .imm_o       (imm)
    );

    rv_alu alu_inst (
        .alu_op_i    (alu_op),
        .a_sel_pc_i  (a_sel_pc),
        .b_sel_imm_i (b_sel_imm),
        .src1_i      (src1_i),
        .src2_i      (src2_i),
        .pc_i        (pc_i),
        .imm_i       (imm),
        .rslt_o      (alu_rslt)
    );

    rv_multiplier multiplier_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (mul_start),
        .mul_op_i (mul_op),
        .src1_i   (src1_i),
        .src2_i   (src2_i),
        .valid_o  (mul_valid),
        .rslt_o   (mul_rslt)
    );

    rv_divider divider_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (div_start),
        .div_op_i (div_op),
        .src1_i   (src1_i),
        .src2_i   (src2_i),
        .valid_o  (div_valid),
        .rslt_o   (div_rslt)
    );

    rv_exec_ctrl ctrl_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .issue_i     (issue_i),
        .unit_sel_i  (unit_sel),
        .alu_rslt_i  (alu_rslt),
        .mul_valid_i (mul_valid),
        .mul_rslt_i  (mul_rslt),
        .div_valid_i (div_valid),
        .div_rslt_i  (div_rslt),
        .mul_start_o (mul_start),
        .div_start_o (div_start),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .illegal_o   (illegal_o),
        .rslt_o      (rslt_o)
    );

endmodule

//--- logic/rv_multiplier.sv
// ----------------------------------------------------------
// Two-stage 33x33 multiplier for MUL, MULH, MULHSU, MULHU.
// Operands are taken on start_i, valid_o follows two cycles
// later with the low or high word of the product.
// ----------------------------------------------------------
module rv_multiplier import rv_exec_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    start_i,
    input  mul_op_t mul_op_i,
    input  word_t   src1_i,
    input  word_t   src2_i,
    output logic    valid_o,
    output word_t   rslt_o
);

    logic signed [32:0] opa_q;
    logic signed [32:0] opb_q;
    logic               high_q;
    logic               stage1_q;
    logic signed [65:0] full_prod;
    logic        [63:0] prod_q;

    assign full_prod = opa_q * opb_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            stage1_q <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            stage1_q <= start_i;
            valid_o  <= stage1_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            opa_q  <= {(mul_op_i != OP_MULHU) & src1_i[31], src1_i};   // MULH, MULHSU
            opb_q  <= {(mul_op_i == OP_MULH) & src2_i[31], src2_i};
            high_q <= (mul_op_i != OP_MUL);
        end
        if (stage1_q) prod_q <= full_prod[63:0];
    end

    assign rslt_o = high_q ? prod_q[63:32] : prod_q[31:0];

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the execute unit testbench with Verilator, run it and look for the pass message
verilator --binary --timing --assert -f rv_exec_unit.f --top-module rv_exec_unit_tb \
    -Mdir obj_dir || { echo "BUILD FAILED"; exit 1; }
out=$(./obj_dir/Vrv_exec_unit_tb +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -q "Done: no errors" && echo "PASS" || { echo "FAIL"; exit 1; }

//--- rv_exec_unit.f
+incdir+logic
logic/rv_exec_pkg.sv
logic/rv_decoder.sv
logic/rv_alu.sv
logic/rv_multiplier.sv
logic/rv_divider.sv
logic/rv_exec_ctrl.sv
logic/rv_exec_unit.sv
testbench/rv_exec_unit_props.sv
testbench/rv_exec_unit_tb.sv

//--- testbench/rv_exec_unit_props.sv
// ----------------------------------------------------------
// Bound checker for the execute unit. Models each issued
// instruction from the RV32IM rules and asserts the result,
// the latency and the issue/done handshake.
// ----------------------------------------------------------
`include "rv_exec_cfg.svh"

module rv_exec_unit_props import rv_exec_pkg::*; (
    input logic  clk_i,
    input logic  rst_i,
    input logic  issue_i,
    input word_t instr_i,
    input word_t pc_i,
    input word_t src1_i,
    input word_t src2_i,
    input logic  busy_o,
    input logic  done_o,
    input logic  illegal_o,
    input word_t rslt_o
);

    int unsigned fail_cnt = 0;      // Read by the testbench
    logic        pending;
    int          cycles;
    int          exp_lat;
    word_t       exp_rslt;
    logic        exp_ill;
    unit_sel_t   kind;
    logic [4:0]  op;
    logic        is_m;

    assign op   = instr_i[6:2];
    assign is_m = (op == `RV_OP_OP) && (instr_i[31:25] == `RV_F7_MULDIV);

    // Reference result straight from the ISA definitions
    function automatic word_t model_result(word_t ins, word_t pc, word_t a, word_t b);
        logic [2:0]         f3;
        logic [6:0]         f7;
        word_t              bb;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] ua;
        logic signed [63:0] ub;
        logic [63:0]        p_ss;
        logic [63:0]        p_su;
        logic [63:0]        p_uu;
        logic               ovf;
        f3   = ins[14:12];
        f7   = ins[31:25];
        bb   = (ins[6:2] == `RV_OP_OPIMM) ? {{20{ins[31]}}, ins[31:20]} : b;
        sa   = 64'($signed(a));
        sb   = 64'($signed(b));
        ua   = {32'b0, a};
        ub   = {32'b0, b};
        p_ss = sa * sb;
        p_su = sa * ub;
        p_uu = ua * ub;
        ovf  = (a == 32'h8000_0000) && (b == '1);   // Signed overflow
        if (ins[1:0] != 2'b11) return '0;
        case (ins[6:2])
            `RV_OP_LUI:              return {ins[31:12], 12'b0};
            `RV_OP_AUIPC:            return pc + {ins[31:12], 12'b0};
            `RV_OP_OP, `RV_OP_OPIMM: ;
            default:                 return '0;
        endcase
        if (ins[6:2] == `RV_OP_OP && f7 == `RV_F7_MULDIV) begin
            case (f3)
                3'd0: return p_ss[31:0];
                3'd1: return p_ss[63:32];
                3'd2: return p_su[63:32];
                3'd3: return p_uu[63:32];
                3'd4: begin
                    if (b == '0) return '1;
                    if (ovf) return a;
                    return $signed(a) / $signed(b);
                end
                3'd5: begin
                    if (b == '0) return '1;
                    return a / b;
                end
                3'd6: begin
                    if (b == '0) return a;
                    if (ovf) return '0;
                    return $signed(a) % $signed(b);
                end
                default: begin
                    if (b == '0) return a;
                    return a % b;
                end
            endcase
        end
        case (f3)
            3'd0: return (ins[6:2] == `RV_OP_OP && f7 == `RV_F7_ALT) ? a - bb : a + bb;
            3'd1: return a << bb[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(bb)};
            3'd3: return {31'b0, a < bb};
            3'd4: return a ^ bb;
            3'd5: return (f7 == `RV_F7_ALT) ? word_t'($signed(a) >>> bb[4:0]) : a >> bb[4:0];
            3'd6: return a | bb;
            default: return a & bb;
        endcase
    endfunction

    // Capture the expectation of every accepted issue
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending <= 1'b0;
            cycles  <= 0;
        end else if (issue_i && !busy_o) begin
            pending  <= 1'b1;
            cycles   <= 1;
            exp_rslt <= model_result(instr_i, pc_i, src1_i, src2_i);
            exp_ill  <= (instr_i[1:0] != 2'b11)
                     || !(op inside {`RV_OP_OP, `RV_OP_OPIMM, `RV_OP_LUI, `RV_OP_AUIPC});
            kind     <= !is_m ? UNIT_ALU : (instr_i[14] ? UNIT_DIV : UNIT_MUL);
            if (is_m && instr_i[14])
                exp_lat <= (src2_i == '0) ? 3 : `RV_DIV_STEPS + 3;
            else
                exp_lat <= is_m ? 3 : 1;
        end else if (pending) begin
            cycles <= cycles + 1;
            if (done_o) pending <= 1'b0;
        end
    end

    // ------------------------------------------------------
    // Handshake and latency
    // ------------------------------------------------------
    idle_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
        !pending |-> !busy_o && !done_o && !illegal_o)
        else begin
            $error("error idle_quiet: expected busy/done/illegal 000, actual %b%b%b",
                   $sampled(busy_o), $sampled(done_o), $sampled(illegal_o));
            fail_cnt++;
        end

    busy_held: assert property (@(posedge clk_i) disable iff (rst_i) pending |-> busy_o)
        else begin
            $error("error busy_held: expected 1, actual %b", $sampled(busy_o));
            fail_cnt++;
        end

    done_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        pending |-> done_o == (cycles == exp_lat))
        else begin
            $error("error done_latency: expected done at cycle %0d, actual done_o %b at %0d",
                   exp_lat, $sampled(done_o), $sampled(cycles));
            fail_cnt++;
        end

    // Flag only in the done cycle of an unsupported instruction
    illegal_flag: assert property (@(posedge clk_i) disable iff (rst_i)
        pending |-> illegal_o == (done_o && exp_ill))
        else begin
            $error("error illegal_flag: expected %b, actual %b",
                   $sampled(done_o) && exp_ill, $sampled(illegal_o));
            fail_cnt++;
        end

    // ------------------------------------------------------
    // Results per unit
    // ------------------------------------------------------
    alu_result: assert property (@(posedge clk_i) disable iff (rst_i)
        pending && done_o && kind == UNIT_ALU |-> rslt_o == exp_rslt)
        else begin
            $error("error alu_result: expected %h, actual %h", exp_rslt, $sampled(rslt_o));
            fail_cnt++;
        end

    mul_result: assert property (@(posedge clk_i) disable iff (rst_i)
        pending && done_o && kind == UNIT_MUL |-> rslt_o == exp_rslt)
        else begin
            $error("error mul_result: expected %h, actual %h", exp_rslt, $sampled(rslt_o));
            fail_cnt++;
        end

    div_result: assert property (@(posedge clk_i) disable iff (rst_i)
        pending && done_o && kind == UNIT_DIV |-> rslt_o == exp_rslt)
        else begin
            $error("error div_result: expected %h, actual %h", exp_rslt, $sampled(rslt_o));
            fail_cnt++;
        end

endmodule

bind rv_exec_unit rv_exec_unit_props props_inst (.*);

//--- testbench/rv_exec_unit_tb.sv
// ----------------------------------------------------------
// Testbench for the execute unit. Issues every supported
// form with random and corner operands, one at a time; the
// bound checker does all result and timing checks.
// ----------------------------------------------------------
`include "rv_exec_cfg.svh"

module rv_exec_unit_tb import rv_exec_pkg::*; ();

    localparam int N_FORMS = 30;              // Instruction forms issued below
    localparam int N_TESTS = N_FORMS * 16;    // 4 x 4 operand pairs per form

    logic  clk_i;
    logic  rst_i;
    logic  issue_i;
    word_t instr_i;
    word_t pc_i;
    word_t src1_i;
    word_t src2_i;
    logic  busy_o;
    logic  done_o;
    logic  illegal_o;
    word_t rslt_o;
    int    seed = 94;

    rv_exec_unit rv_exec_unit_inst (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .issue_i   (issue_i),
        .instr_i   (instr_i),
        .pc_i      (pc_i),
        .src1_i    (src1_i),
        .src2_i    (src2_i),
        .busy_o    (busy_o),
        .done_o    (done_o),
        .illegal_o (illegal_o),
        .rslt_o    (rslt_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // Random value or one of the corner operands
    function automatic word_t pick_operand(int k);
        case (k)
            0:       return $random(seed);
            1:       return '0;
            2:       return '1;
            default: return 32'h8000_0000;
        endcase
    endfunction

    // One instruction, then wait for its done strobe
    task automatic issue_op(input word_t instr, input word_t pc, input word_t a, input word_t b);
        @(posedge clk_i);
        issue_i <= 1'b1;
        instr_i <= instr;
        pc_i    <= pc;
        src1_i  <= a;
        src2_i  <= b;
        @(posedge clk_i);
        issue_i <= 1'b0;
        do @(posedge clk_i); while (!done_o);
    endtask

    task automatic run_form(input logic [4:0] op, input logic [2:0] f3, input logic [6:0] f7,
                            input logic rand_hi);
        word_t instr;
        for (int ka = 0; ka < 4; ka++) begin
            for (int kb = 0; kb < 4; kb++) begin
                instr = {f7, 5'($random(seed)), 5'd1, f3, 5'd3, op, 2'b11};
                if (rand_hi) instr[31:25] = 7'($random(seed));   // Immediate bits
                issue_op(instr, $random(seed), pick_operand(ka), pick_operand(kb));
            end
        end
    endtask

    initial begin
        rst_i   <= 1'b1;
        issue_i <= 1'b0;
        instr_i <= '0;
        pc_i    <= '0;
        src1_i  <= '0;
        src2_i  <= '0;
        repeat (10) @(posedge clk_i);
        rst_i <= 1'b0;
        repeat (3) @(posedge clk_i);           // Idle outputs after reset
        for (int f3 = 0; f3 < 8; f3++) begin
            run_form(`RV_OP_OP, 3'(f3), 7'h00, 1'b0);
            run_form(`RV_OP_OP, 3'(f3), `RV_F7_MULDIV, 1'b0);
            if (f3 != 1 && f3 != 5) run_form(`RV_OP_OPIMM, 3'(f3), 7'h00, 1'b1);
        end
        run_form(`RV_OP_OP, 3'd0, `RV_F7_ALT, 1'b0);        // SUB
        run_form(`RV_OP_OP, 3'd5, `RV_F7_ALT, 1'b0);        // SRA
        run_form(`RV_OP_OPIMM, 3'd1, 7'h00, 1'b0);          // SLLI
        run_form(`RV_OP_OPIMM, 3'd5, 7'h00, 1'b0);          // SRLI
        run_form(`RV_OP_OPIMM, 3'd5, `RV_F7_ALT, 1'b0);     // SRAI
        run_form(`RV_OP_LUI, 3'd0, 7'h00, 1'b1);
        run_form(`RV_OP_AUIPC, 3'd0, 7'h00, 1'b1);
        run_form(5'b00000, 3'd2, 7'h00, 1'b1);              // LW opcode, unsupported
        repeat (2) @(posedge clk_i);
        if (rv_exec_unit_inst.props_inst.fail_cnt == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "%0d assertion failures", rv_exec_unit_inst.props_inst.fail_cnt);
        end
    end

    // Stop at the first failed assertion
    initial begin : fail_monitor
        do @(posedge clk_i); while (rv_exec_unit_inst.props_inst.fail_cnt == 0);
        $display("Done: errors found");
        $fatal(1, "assertion failed in the bound checker");
    end

    initial begin : watchdog
        repeat (N_TESTS * 40 + 20) @(posedge clk_i);
        $display("Done: errors found");
        $fatal(1, "timeout: tests did not finish within %0d cycles", N_TESTS * 40);
    end

endmodule
